// ==== src/ddram_pkg.sv ====
// ddr front end shared definitions
package ddram_pkg;

	typedef logic [28:0] ddr_addr_t;
	typedef logic [63:0] ddr_data_t;
	typedef logic [7:0]  ddr_be_t;
	typedef logic [7:0]  burst_t;

	// workh word address from byte address bits 19:2
	typedef logic [17:0] workh_addr_t;
	// cdram halfword address from byte address bits 18:1
	typedef logic [17:0] cdram_addr_t;

	typedef logic [31:0] word32_t;
	typedef logic [15:0] word16_t;

	typedef enum logic {CH_WORKH, CH_CDRAM} chan_t;
	typedef enum logic [1:0] {SEQ_IDLE, SEQ_WRITE, SEQ_FILL} seq_state_t;

	// qword bases of the two regions
	localparam ddr_addr_t WORKH_BASE = 29'h0606_0000;
	localparam ddr_addr_t CDRAM_BASE = 29'h0610_0000;

	localparam int WORKH_LINE_LOG2 = 2;
	localparam int CDRAM_LINE_LOG2 = 1;
	localparam burst_t WORKH_BURST = burst_t'(2 ** WORKH_LINE_LOG2);
	localparam burst_t CDRAM_BURST = burst_t'(2 ** CDRAM_LINE_LOG2);
	localparam int FILL_IDX_W = (WORKH_LINE_LOG2 > CDRAM_LINE_LOG2) ?
		WORKH_LINE_LOG2 : CDRAM_LINE_LOG2;

	// log2 of port words per qword
	localparam int WORKH_WSEL_W = 1;
	localparam int CDRAM_WSEL_W = 2;
	localparam int WORKH_LINE_W = $bits(workh_addr_t) - WORKH_WSEL_W - WORKH_LINE_LOG2;
	localparam int CDRAM_LINE_W = $bits(cdram_addr_t) - CDRAM_WSEL_W - CDRAM_LINE_LOG2;

	localparam int WORKH_BE_W = 4;
	localparam int CDRAM_BE_W = 2;

	localparam int WORKH_FIFO_DEPTH = 8;
	localparam int CDRAM_FIFO_DEPTH = 1;
	// queue entry is {addr, byte enables, data}
	localparam int WORKH_ENTRY_W = $bits(workh_addr_t) + WORKH_BE_W + $bits(word32_t);
	localparam int CDRAM_ENTRY_W = $bits(cdram_addr_t) + CDRAM_BE_W + $bits(word16_t);

endpackage

// ==== src/ddr_port_cache.sv ====
// port read line cache
`timescale 1ns/1ps

module ddr_port_cache #(
	parameter int ADDR_W = 18,
	parameter int WORD_W = 32,
	parameter int LINE_LOG2 = 2,
	localparam int WSEL_W = $clog2(64 / WORD_W),
	localparam int LINE_W = ADDR_W - WSEL_W - LINE_LOG2
) (
	input  logic                 CLK,
	input  logic                 rst_pulse,

	input  logic [ADDR_W-1:0]    addr,
	input  logic                 rd,
	input  logic [WORD_W/8-1:0]  wr,
	output logic [WORD_W-1:0]    dout,
	output logic                 read_busy,
	output logic                 wr_start,

	output logic                 fill_req,
	output logic [LINE_W-1:0]    fill_line,
	input  logic                 fill_we,
	input  logic [LINE_LOG2-1:0] fill_index,
	input  ddram_pkg::ddr_data_t fill_data,
	input  logic                 fill_done
);
	import ddram_pkg::*;

	logic              rd_old;
	logic              wr_old;
	logic              rd_edge;
	logic              same_line;
	logic              stale;
	logic [ADDR_W-1:0] cache_addr;
	logic [WSEL_W-1:0] lane;
	ddr_data_t         line_mem [2**LINE_LOG2];
	ddr_data_t         line_q;

	assign rd_edge   = rd & ~rd_old;
	assign wr_start  = (|wr) & ~wr_old;
	assign fill_line = cache_addr[ADDR_W-1 -: LINE_W];
	assign same_line = addr[ADDR_W-1 -: LINE_W] == fill_line;
	assign fill_req  = read_busy;

	always_ff @(posedge CLK) begin
		if (rst_pulse) begin
			rd_old     <= 1'b0;
			wr_old     <= 1'b0;
			stale      <= 1'b1;
			read_busy  <= 1'b0;
			cache_addr <= '0;
		end else begin
			rd_old <= rd;
			wr_old <= |wr;

			if (rd_edge) begin
				if (!same_line || stale) begin
					read_busy <= 1'b1;
				end
				cache_addr <= addr;
				stale      <= 1'b0;
			end

			// a write into the held line forces a refetch
			if (wr_start && same_line) begin
				stale <= 1'b1;
			end

			if (fill_done) begin
				read_busy <= 1'b0;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (fill_we) begin
			line_mem[fill_index] <= fill_data;
		end
	end

	// word 0 sits in the top bits of the qword
	assign line_q = line_mem[cache_addr[WSEL_W +: LINE_LOG2]];
	assign lane   = ~cache_addr[WSEL_W-1:0];
	assign dout   = line_q[lane * WORD_W +: WORD_W];

endmodule

// ==== src/ddr_write_fifo.sv ====
// posted write queue
`timescale 1ns/1ps

module ddr_write_fifo #(
	parameter int DEPTH = 8,
	parameter int ENTRY_W = 54
) (
	input  logic               CLK,
	input  logic               rst_pulse,

	input  logic               push,
	input  logic [ENTRY_W-1:0] entry_in,

	input  logic               pop,
	output logic [ENTRY_W-1:0] entry_out,

	output logic               empty,
	output logic               full
);
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	logic [ENTRY_W-1:0] mem [DEPTH];
	logic [PTR_W-1:0]   wr_ptr;
	logic [PTR_W-1:0]   rd_ptr;
	logic [CNT_W-1:0]   count;
	logic               do_push;
	logic               do_pop;

	assign empty   = count == '0;
	assign full    = count == CNT_W'(DEPTH);
	assign do_push = push & ~full;
	assign do_pop  = pop & ~empty;

	always_ff @(posedge CLK) begin
		if (rst_pulse) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (do_push) begin
			mem[wr_ptr] <= entry_in;
		end
	end

	assign entry_out = mem[rd_ptr];

endmodule

// ==== src/ddr_burst_sequencer.sv ====
// ddr command sequencer
`timescale 1ns/1ps

module ddr_burst_sequencer (
	input  logic                                CLK,
	input  logic                                rst_pulse,

	input  logic                                ddr_busy,
	output ddram_pkg::burst_t                   ddr_burstcnt,
	output ddram_pkg::ddr_addr_t                ddr_addr,
	input  logic                                ddr_dout_ready,
	output logic                                ddr_rd,
	output ddram_pkg::ddr_data_t                ddr_din,
	output ddram_pkg::ddr_be_t                  ddr_be,
	output logic                                ddr_we,

	input  logic                                workh_q_empty,
	input  logic [ddram_pkg::WORKH_ENTRY_W-1:0] workh_q_entry,
	output logic                                workh_pop,
	input  logic                                cdram_q_empty,
	input  logic [ddram_pkg::CDRAM_ENTRY_W-1:0] cdram_q_entry,
	output logic                                cdram_pop,

	input  logic                                workh_fill_req,
	input  logic [ddram_pkg::WORKH_LINE_W-1:0]  workh_fill_line,
	input  logic                                cdram_fill_req,
	input  logic [ddram_pkg::CDRAM_LINE_W-1:0]  cdram_fill_line,

	output logic                                workh_fill_we,
	output logic                                cdram_fill_we,
	output logic [ddram_pkg::FILL_IDX_W-1:0]    fill_index,
	output logic                                workh_fill_done,
	output logic                                cdram_fill_done
);
	import ddram_pkg::*;

	seq_state_t            state;
	chan_t                 chan;
	logic [FILL_IDX_W-1:0] beat_cnt;
	logic                  beat;
	logic                  last_beat;

	workh_addr_t           wh_addr;
	logic [WORKH_BE_W-1:0] wh_be;
	word32_t               wh_data;
	cdram_addr_t           cd_addr;
	logic [CDRAM_BE_W-1:0] cd_be;
	word16_t               cd_data;

	assign {wh_addr, wh_be, wh_data} = workh_q_entry;
	assign {cd_addr, cd_be, cd_data} = cdram_q_entry;

	// a beat counts only when the bus is not stalled
	assign beat      = (state == SEQ_FILL) && ddr_dout_ready && !ddr_busy;
	assign last_beat = burst_t'(beat_cnt) == ddr_burstcnt - burst_t'(1);

	assign workh_pop = (state == SEQ_WRITE) && !ddr_busy && (chan == CH_WORKH);
	assign cdram_pop = (state == SEQ_WRITE) && !ddr_busy && (chan == CH_CDRAM);

	assign workh_fill_we   = beat && (chan == CH_WORKH);
	assign cdram_fill_we   = beat && (chan == CH_CDRAM);
	assign workh_fill_done = workh_fill_we && last_beat;
	assign cdram_fill_done = cdram_fill_we && last_beat;
	assign fill_index      = beat_cnt;

	always_ff @(posedge CLK) begin
		if (rst_pulse) begin
			state    <= SEQ_IDLE;
			chan     <= CH_WORKH;
			ddr_rd   <= 1'b0;
			ddr_we   <= 1'b0;
			beat_cnt <= '0;
		end else if (!ddr_busy) begin
			ddr_rd <= 1'b0;
			ddr_we <= 1'b0;

			case (state)
				SEQ_IDLE: begin
					if (!workh_q_empty) begin
						ddr_addr <= WORKH_BASE +
							ddr_addr_t'(wh_addr[$bits(workh_addr_t)-1:WORKH_WSEL_W]);
						ddr_din <= {2{wh_data}};
						// lower word index takes the upper lanes
						ddr_be <= {wh_be, {(8 - WORKH_BE_W){1'b0}}} >>
							(WORKH_BE_W * wh_addr[WORKH_WSEL_W-1:0]);
						ddr_burstcnt <= burst_t'(1);
						ddr_we       <= 1'b1;
						chan         <= CH_WORKH;
						state        <= SEQ_WRITE;
					end else if (workh_fill_req) begin
						ddr_addr <= WORKH_BASE +
							ddr_addr_t'({workh_fill_line, {WORKH_LINE_LOG2{1'b0}}});
						ddr_be       <= '1;
						ddr_burstcnt <= WORKH_BURST;
						ddr_rd       <= 1'b1;
						beat_cnt     <= '0;
						chan         <= CH_WORKH;
						state        <= SEQ_FILL;
					end else if (!cdram_q_empty) begin
						ddr_addr <= CDRAM_BASE +
							ddr_addr_t'(cd_addr[$bits(cdram_addr_t)-1:CDRAM_WSEL_W]);
						ddr_din <= {4{cd_data}};
						ddr_be <= {cd_be, {(8 - CDRAM_BE_W){1'b0}}} >>
							(CDRAM_BE_W * cd_addr[CDRAM_WSEL_W-1:0]);
						ddr_burstcnt <= burst_t'(1);
						ddr_we       <= 1'b1;
						chan         <= CH_CDRAM;
						state        <= SEQ_WRITE;
					end else if (cdram_fill_req) begin
						ddr_addr <= CDRAM_BASE +
							ddr_addr_t'({cdram_fill_line, {CDRAM_LINE_LOG2{1'b0}}});
						ddr_be       <= '1;
						ddr_burstcnt <= CDRAM_BURST;
						ddr_rd       <= 1'b1;
						beat_cnt     <= '0;
						chan         <= CH_CDRAM;
						state        <= SEQ_FILL;
					end
				end

				// write accepted here and queue head popped
				SEQ_WRITE: begin
					state <= SEQ_IDLE;
				end

				SEQ_FILL: begin
					if (ddr_dout_ready) begin
						beat_cnt <= beat_cnt + 1'b1;
						if (last_beat) begin
							state <= SEQ_IDLE;
						end
					end
				end

				default: begin
					state <= SEQ_IDLE;
				end
			endcase
		end
	end

endmodule

// ==== src/ddram_arbiter.sv ====
// two-port ddr front end
`timescale 1ns/1ps

module ddram_arbiter (
	input  logic                             CLK,
	input  logic                             rst_pulse,

	input  logic                             ddr_busy,
	output ddram_pkg::burst_t                ddr_burstcnt,
	output ddram_pkg::ddr_addr_t             ddr_addr,
	input  ddram_pkg::ddr_data_t             ddr_dout,
	input  logic                             ddr_dout_ready,
	output logic                             ddr_rd,
	output ddram_pkg::ddr_data_t             ddr_din,
	output ddram_pkg::ddr_be_t               ddr_be,
	output logic                             ddr_we,

	input  ddram_pkg::workh_addr_t           workh_addr,
	input  ddram_pkg::word32_t               workh_din,
	input  logic [ddram_pkg::WORKH_BE_W-1:0] workh_wr,
	input  logic                             workh_rd,
	output ddram_pkg::word32_t               workh_dout,
	output logic                             workh_busy,

	input  ddram_pkg::cdram_addr_t           cdram_addr,
	input  ddram_pkg::word16_t               cdram_din,
	input  logic [ddram_pkg::CDRAM_BE_W-1:0] cdram_wr,
	input  logic                             cdram_rd,
	output ddram_pkg::word16_t               cdram_dout,
	output logic                             cdram_busy
);
	import ddram_pkg::*;

	logic                     workh_wr_start;
	logic                     workh_read_busy;
	logic                     workh_fill_req;
	logic [WORKH_LINE_W-1:0]  workh_fill_line;
	logic                     workh_fill_we;
	logic                     workh_fill_done;
	logic                     workh_q_empty;
	logic                     workh_q_full;
	logic [WORKH_ENTRY_W-1:0] workh_q_entry;
	logic                     workh_pop;

	logic                     cdram_wr_start;
	logic                     cdram_read_busy;
	logic                     cdram_fill_req;
	logic [CDRAM_LINE_W-1:0]  cdram_fill_line;
	logic                     cdram_fill_we;
	logic                     cdram_fill_done;
	logic                     cdram_q_empty;
	logic                     cdram_q_full;
	logic [CDRAM_ENTRY_W-1:0] cdram_q_entry;
	logic                     cdram_pop;

	logic [FILL_IDX_W-1:0]    fill_index;

	assign workh_busy = workh_q_full | workh_read_busy;
	assign cdram_busy = cdram_q_full | cdram_read_busy;

	ddr_port_cache #(
		.ADDR_W    ($bits(workh_addr_t)),
		.WORD_W    ($bits(word32_t)),
		.LINE_LOG2 (WORKH_LINE_LOG2)
	) workh_cache (
		.CLK        (CLK),
		.rst_pulse  (rst_pulse),
		.addr       (workh_addr),
		.rd         (workh_rd),
		.wr         (workh_wr),
		.dout       (workh_dout),
		.read_busy  (workh_read_busy),
		.wr_start   (workh_wr_start),
		.fill_req   (workh_fill_req),
		.fill_line  (workh_fill_line),
		.fill_we    (workh_fill_we),
		.fill_index (fill_index[WORKH_LINE_LOG2-1:0]),
		.fill_data  (ddr_dout),
		.fill_done  (workh_fill_done)
	);

	ddr_port_cache #(
		.ADDR_W    ($bits(cdram_addr_t)),
		.WORD_W    ($bits(word16_t)),
		.LINE_LOG2 (CDRAM_LINE_LOG2)
	) cdram_cache (
		.CLK        (CLK),
		.rst_pulse  (rst_pulse),
		.addr       (cdram_addr),
		.rd         (cdram_rd),
		.wr         (cdram_wr),
		.dout       (cdram_dout),
		.read_busy  (cdram_read_busy),
		.wr_start   (cdram_wr_start),
		.fill_req   (cdram_fill_req),
		.fill_line  (cdram_fill_line),
		.fill_we    (cdram_fill_we),
		.fill_index (fill_index[CDRAM_LINE_LOG2-1:0]),
		.fill_data  (ddr_dout),
		.fill_done  (cdram_fill_done)
	);

	ddr_write_fifo #(
		.DEPTH   (WORKH_FIFO_DEPTH),
		.ENTRY_W (WORKH_ENTRY_W)
	) workh_fifo (
		.CLK       (CLK),
		.rst_pulse (rst_pulse),
		.push      (workh_wr_start),
		.entry_in  ({workh_addr, workh_wr, workh_din}),
		.pop       (workh_pop),
		.entry_out (workh_q_entry),
		.empty     (workh_q_empty),
		.full      (workh_q_full)
	);

	// single-entry posted write register
	ddr_write_fifo #(
		.DEPTH   (CDRAM_FIFO_DEPTH),
		.ENTRY_W (CDRAM_ENTRY_W)
	) cdram_fifo (
		.CLK       (CLK),
		.rst_pulse (rst_pulse),
		.push      (cdram_wr_start),
		.entry_in  ({cdram_addr, cdram_wr, cdram_din}),
		.pop       (cdram_pop),
		.entry_out (cdram_q_entry),
		.empty     (cdram_q_empty),
		.full      (cdram_q_full)
	);

	ddr_burst_sequencer sequencer (
		.CLK             (CLK),
		.rst_pulse       (rst_pulse),
		.ddr_busy        (ddr_busy),
		.ddr_burstcnt    (ddr_burstcnt),
		.ddr_addr        (ddr_addr),
		.ddr_dout_ready  (ddr_dout_ready),
		.ddr_rd          (ddr_rd),
		.ddr_din         (ddr_din),
		.ddr_be          (ddr_be),
		.ddr_we          (ddr_we),
		.workh_q_empty   (workh_q_empty),
		.workh_q_entry   (workh_q_entry),
		.workh_pop       (workh_pop),
		.cdram_q_empty   (cdram_q_empty),
		.cdram_q_entry   (cdram_q_entry),
		.cdram_pop       (cdram_pop),
		.workh_fill_req  (workh_fill_req),
		.workh_fill_line (workh_fill_line),
		.cdram_fill_req  (cdram_fill_req),
		.cdram_fill_line (cdram_fill_line),
		.workh_fill_we   (workh_fill_we),
		.cdram_fill_we   (cdram_fill_we),
		.fill_index      (fill_index),
		.workh_fill_done (workh_fill_done),
		.cdram_fill_done (cdram_fill_done)
	);

endmodule

// ==== tb/tb_clock_gen.sv ====
// testbench clock and reset
`timescale 1ns/1ps

module tb_clock_gen (
	output logic CLK,
	output logic rst_pulse
);
	initial begin
		CLK = 1'b0;
		forever #5 CLK = ~CLK;
	end

	// reset held for two rising edges
	initial begin
		rst_pulse = 1'b1;
		repeat (2) @(posedge CLK);
		#1 rst_pulse = 1'b0;
	end
endmodule

// ==== tb/ddr_mem_model.sv ====
// ddr memory model
`timescale 1ns/1ps

module ddr_mem_model #(
	parameter logic [63:0] FILL = 64'h0
) (
	input  logic        CLK,
	input  logic        rst_pulse,
	output logic        ddr_busy,
	input  logic [7:0]  ddr_burstcnt,
	input  logic [28:0] ddr_addr,
	output logic [63:0] ddr_dout,
	output logic        ddr_dout_ready,
	input  logic        ddr_rd,
	input  logic [63:0] ddr_din,
	input  logic [7:0]  ddr_be,
	input  logic        ddr_we
);
	logic [63:0] mem [logic [28:0]];
	logic [31:0] rng_state = 32'd56940;
	logic [28:0] cur_addr;
	int          beats_left;
	int          lat;
	logic        busy_q;
	logic        ready_q;

	function automatic logic [31:0] rand_step();
		rng_state = rng_state * 32'd1103515245 + 32'd12345;
		return rng_state >> 16;
	endfunction

	function automatic logic [63:0] read_q(logic [28:0] a);
		if (mem.exists(a)) return mem[a];
		return {35'b0, a} ^ FILL;
	endfunction

	initial begin
		ddr_busy       = 1'b0;
		ddr_dout       = '0;
		ddr_dout_ready = 1'b0;
	end

	always @(posedge CLK) begin
		if (rst_pulse) begin
			beats_left = 0;
			lat        = 0;
			busy_q     = 1'b0;
			ready_q    = 1'b0;
		end else begin
			// a beat driven last cycle was taken at this edge
			if (ready_q && !busy_q) begin
				beats_left = beats_left - 1;
				cur_addr   = cur_addr + 1'b1;
			end
			if (ddr_we && !busy_q) begin
				mem[ddr_addr] = read_q(ddr_addr);
				for (int i = 0; i < 8; i++)
					if (ddr_be[i]) mem[ddr_addr][8*i +: 8] = ddr_din[8*i +: 8];
			end
			if (ddr_rd && !busy_q) begin
				cur_addr   = ddr_addr;
				beats_left = int'(ddr_burstcnt);
				lat        = 1 + int'(rand_step() % 5);
			end
			if (beats_left != 0 && lat == 0) begin
				ready_q = 1'b1;
				busy_q  = 1'b0;
			end else begin
				ready_q = 1'b0;
				if (lat != 0) lat = lat - 1;
				busy_q = (rand_step() % 3) == 0;
			end
		end
		ddr_busy       <= #1 busy_q;
		ddr_dout_ready <= #1 ready_q;
		ddr_dout       <= #1 read_q(cur_addr);
	end
endmodule

// ==== tb/tb_ddram_arbiter.sv ====
// ddr front end testbench
`timescale 1ns/1ps

module tb_ddram_arbiter;
	import ddram_pkg::*;

	localparam logic [63:0] FILL = 64'hA5C3_0F96_5A3C_F069;
	localparam int N_WR = 40;
	localparam int N_BURST = 48;
	localparam int NUM_OPS = 2 * N_WR + 128 + 16 + 18 + N_BURST + 64;

	logic CLK, rst_pulse, ddr_busy, ddr_dout_ready, ddr_rd, ddr_we;
	burst_t burstcnt;
	ddr_addr_t ddr_addr;
	ddr_data_t ddr_dout, ddr_din;
	ddr_be_t ddr_be;
	workh_addr_t workh_addr;
	word32_t workh_din, workh_dout;
	logic [3:0] workh_wr;
	logic workh_rd, workh_busy;
	cdram_addr_t cdram_addr;
	word16_t cdram_din, cdram_dout;
	logic [1:0] cdram_wr;
	logic cdram_rd, cdram_busy;

	ddr_data_t shadow [ddr_addr_t];
	logic [31:0] rng_state = 32'd56940;
	int errors = 0;
	int checks = 0;
	int rd_count = 0;
	int wh_q_cnt = 0;
	logic wh_wr_prev = 1'b0;
	logic wh_seen_full = 1'b0;

	tb_clock_gen clk_gen (.CLK(CLK), .rst_pulse(rst_pulse));

	ddr_mem_model #(.FILL(FILL)) mem (
		.CLK(CLK), .rst_pulse(rst_pulse), .ddr_busy(ddr_busy), .ddr_burstcnt(burstcnt),
		.ddr_addr(ddr_addr), .ddr_dout(ddr_dout), .ddr_dout_ready(ddr_dout_ready),
		.ddr_rd(ddr_rd), .ddr_din(ddr_din), .ddr_be(ddr_be), .ddr_we(ddr_we)
	);

	ddram_arbiter DUT (
		.CLK(CLK), .rst_pulse(rst_pulse), .ddr_busy(ddr_busy), .ddr_burstcnt(burstcnt),
		.ddr_addr(ddr_addr), .ddr_dout(ddr_dout), .ddr_dout_ready(ddr_dout_ready),
		.ddr_rd(ddr_rd), .ddr_din(ddr_din), .ddr_be(ddr_be), .ddr_we(ddr_we),
		.workh_addr(workh_addr), .workh_din(workh_din), .workh_wr(workh_wr),
		.workh_rd(workh_rd), .workh_dout(workh_dout), .workh_busy(workh_busy),
		.cdram_addr(cdram_addr), .cdram_din(cdram_din), .cdram_wr(cdram_wr),
		.cdram_rd(cdram_rd), .cdram_dout(cdram_dout), .cdram_busy(cdram_busy)
	);

	function automatic logic [31:0] next_rand();
		rng_state = rng_state * 32'd1103515245 + 32'd12345;
		return rng_state >> 16;
	endfunction

	function automatic ddr_data_t shadow_get(ddr_addr_t q);
		if (shadow.exists(q)) return shadow[q];
		return {35'b0, q} ^ FILL;
	endfunction

	// qword that holds a port word
	function automatic ddr_addr_t qword_of(bit cd, logic [17:0] a);
		return cd ? CDRAM_BASE + ddr_addr_t'(a[17:2]) : WORKH_BASE + ddr_addr_t'(a[17:1]);
	endfunction

	// lowest bit of a port word within its qword with word 0 on top
	function automatic int lane_base(bit cd, logic [17:0] a);
		return cd ? 48 - 16 * int'(a[1:0]) : (a[0] ? 0 : 32);
	endfunction

	function automatic word32_t exp_word(bit cd, logic [17:0] a);
		ddr_data_t q;
		q = shadow_get(qword_of(cd, a));
		return cd ? 32'(q[lane_base(cd, a) +: 16]) : q[lane_base(cd, a) +: 32];
	endfunction

	function automatic bit in_wh(ddr_addr_t q);
		return q >= WORKH_BASE && q < WORKH_BASE + 29'(2 ** 17);
	endfunction

	function automatic bit in_cd(ddr_addr_t q);
		return q >= CDRAM_BASE && q < CDRAM_BASE + 29'(2 ** 16);
	endfunction

	task automatic wait_idle(bit cd);
		@(posedge CLK);
		#1;
		while (cd ? cdram_busy : workh_busy) begin
			@(posedge CLK);
			#1;
		end
	endtask

	task automatic do_write(bit cd, logic [17:0] a, word32_t d, logic [3:0] be);
		ddr_data_t q;
		q = shadow_get(qword_of(cd, a));
		for (int j = 0; j < (cd ? 2 : 4); j++)
			if (be[j]) q[lane_base(cd, a) + 8*j +: 8] = d[8*j +: 8];
		shadow[qword_of(cd, a)] = q;
		if (cd) begin
			cdram_addr = a;
			cdram_din  = d[15:0];
			cdram_wr   = be[1:0];
		end else begin
			workh_addr = a;
			workh_din  = d;
			workh_wr   = be;
		end
		@(posedge CLK);
		#1;
		workh_wr = '0;
		cdram_wr = '0;
		checks++;
		if (cd) begin
			assert (cdram_busy) else begin
				errors++;
				$display("MISMATCH cdram_busy: got %h expected %h", cdram_busy, 1'b1);
			end
		end else begin
			assert (workh_busy == (wh_q_cnt == WORKH_FIFO_DEPTH)) else begin
				errors++;
				$display("MISMATCH workh_busy: got %h expected %h", workh_busy,
					wh_q_cnt == WORKH_FIFO_DEPTH);
			end
			if (wh_q_cnt == WORKH_FIFO_DEPTH) wh_seen_full = 1'b1;
		end
		wait_idle(cd);
	endtask

	// mode 0 is a plain read, 1 must hit and 2 must refetch
	task automatic do_read(bit cd, logic [17:0] a, int mode);
		int rd_before;
		word32_t got;
		rd_before = rd_count;
		if (cd) begin
			cdram_addr = a;
			cdram_rd   = 1'b1;
		end else begin
			workh_addr = a;
			workh_rd   = 1'b1;
		end
		@(posedge CLK);
		#1;
		workh_rd = 1'b0;
		cdram_rd = 1'b0;
		if (mode == 1) begin
			checks++;
			assert (!(cd ? cdram_busy : workh_busy)) else begin
				errors++;
				$display("MISMATCH %s at %h: got %h expected %h",
					cd ? "cdram_busy" : "workh_busy", a,
					cd ? cdram_busy : workh_busy, 1'b0);
			end
		end
		while (cd ? cdram_busy : workh_busy) begin
			@(posedge CLK);
			#1;
		end
		got = cd ? 32'(cdram_dout) : workh_dout;
		checks++;
		assert (got == exp_word(cd, a)) else begin
			errors++;
			$display("MISMATCH %s at %h: got %h expected %h",
				cd ? "cdram_dout" : "workh_dout", a, got, exp_word(cd, a));
		end
		@(posedge CLK);
		#1;
		if (mode == 1) begin
			checks++;
			assert (rd_count == rd_before) else begin
				errors++;
				$display("read hit at %h issued a ddr read", a);
			end
		end else if (mode == 2) begin
			checks++;
			assert (rd_count > rd_before) else begin
				errors++;
				$display("read after write to cached line %h issued no ddr read", a);
			end
		end
	endtask

	// bus monitor that also tracks workh queue occupancy
	always @(posedge CLK) begin
		if (!rst_pulse) begin
			if ((|workh_wr) && !wh_wr_prev) wh_q_cnt++;
			wh_wr_prev = |workh_wr;
			if (ddr_we && !ddr_busy) begin
				assert (in_wh(ddr_addr) || in_cd(ddr_addr)) else begin
					errors++;
					$display("ddr write to %h outside both regions", ddr_addr);
				end
				if (in_wh(ddr_addr)) wh_q_cnt--;
			end
			if (ddr_rd && !ddr_busy) begin
				rd_count++;
				assert ((in_wh(ddr_addr) && ddr_addr[1:0] == 0 && burstcnt == 4) ||
					(in_cd(ddr_addr) && ddr_addr[0] == 0 && burstcnt == 2)) else begin
					errors++;
					$display("bad ddr read at %h with burst %0d", ddr_addr, burstcnt);
				end
			end
		end
	end

	initial begin
		#(NUM_OPS * 200 * 10);
		$display("timeout after %0d operations worth of cycles", NUM_OPS);
		$display("CHECKS FAILED");
		$finish;
	end

	initial begin
		logic [17:0] a;
		{workh_addr, workh_din, workh_wr, workh_rd} = '0;
		{cdram_addr, cdram_din, cdram_wr, cdram_rd} = '0;
		wait (rst_pulse == 1'b0);
		@(posedge CLK);
		#1;
		checks++;
		assert (!ddr_rd && !ddr_we && !workh_busy && !cdram_busy) else begin
			errors++;
			$display("MISMATCH {ddr_rd,ddr_we,workh_busy,cdram_busy}: got %h expected %h",
				{ddr_rd, ddr_we, workh_busy, cdram_busy}, 4'h0);
		end
		for (int i = 0; i < N_WR; i++) begin
			do_write(0, 18'(next_rand() % 64), next_rand() ^ (next_rand() << 16),
				4'(next_rand() % 15 + 1));
			do_write(1, 18'(next_rand() % 64), next_rand(), 4'(next_rand() % 3 + 1));
		end
		for (int i = 0; i < 64; i++) do_read(0, 18'(i), 0);
		for (int i = 0; i < 64; i++) do_read(1, 18'(i), 0);
		for (int k = 0; k < 8; k++) begin
			a = 18'(next_rand() % 64);
			do_read(k[0], a, 0);
			do_read(k[0], a ^ 18'd1, 1);
		end
		for (int k = 0; k < 6; k++) begin
			a = 18'(next_rand() % 64);
			do_read(k[0], a, 0);
			do_write(k[0], a, next_rand(), 4'hf);
			do_read(k[0], a, 2);
		end
		for (int i = 0; i < N_BURST; i++)
			do_write(0, 18'(next_rand() % 64), next_rand(), 4'(next_rand() % 15 + 1));
		checks++;
		assert (wh_seen_full) else begin
			errors++;
			$display("workh write queue never reached full during the write burst");
		end
		for (int i = 0; i < 64; i++) do_read(0, 18'(i), 0);
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end
endmodule

// ==== ddram_arbiter.f ====
src/ddram_pkg.sv
src/ddr_port_cache.sv
src/ddr_write_fifo.sv
src/ddr_burst_sequencer.sv
src/ddram_arbiter.sv
tb/tb_clock_gen.sv
tb/ddr_mem_model.sv
tb/tb_ddram_arbiter.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the ddram_arbiter simulation with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--top-module tb_ddram_arbiter \
	-f ddram_arbiter.f \
	--Mdir obj_dir -o sim_ddram_arbiter

./obj_dir/sim_ddram_arbiter | tee sim.log

if grep -q "CHECKS FAILED" sim.log; then
	echo "simulation reported failures"
	exit 1
fi
echo "simulation clean"
